/* verilog/i2c_pkg.sv */
package i2c_pkg;

    typedef logic [7:0] byte_t;
    typedef logic [31:0] word_t;
    typedef logic [6:0] slave_addr_t;

    // Data bytes per transfer, MSB first
    localparam int DATA_BYTES = 4;

    // Encoding is the R/W bit sent after the address
    typedef enum logic {
        OP_WRITE = 1'b0,
        OP_READ  = 1'b1
    } op_t;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_START,
        ST_ADDR,
        ST_REG,
        ST_RESTART,
        ST_DATA,
        ST_STOP
    } seq_state_t;

endpackage

/* verilog/i2c_bit_timer.sv */
`timescale 1ns/1ps

module i2c_bit_timer #(
    parameter int SCL_HALF_PERIOD = 4
) (
    input  logic clk,
    input  logic rst,
    input  logic run,
    output logic scl,
    output logic scl_rise,
    output logic scl_fall
);

    localparam int CNT_W = $clog2(SCL_HALF_PERIOD);
    localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(SCL_HALF_PERIOD - 1);

    logic [CNT_W-1:0] cnt;
    logic edge_due;

    // Last cycle of a half period, SCL toggles on the next edge
    assign edge_due = run && (cnt == CNT_LAST);
    assign scl_rise = edge_due && !scl;
    assign scl_fall = edge_due && scl;

    always_ff @(posedge clk) begin
        if (rst || !run) begin
            cnt <= '0;
            scl <= 1'b1;
        end else if (edge_due) begin
            cnt <= '0;
            scl <= ~scl;
        end else begin
            cnt <= cnt + 1'b1;
        end
    end

endmodule

/* verilog/i2c_byte_shifter.sv */
`timescale 1ns/1ps

module i2c_byte_shifter (
    input  logic           clk,
    input  logic           rst,
    input  logic           load,
    input  i2c_pkg::byte_t load_byte,
    input  logic           read_mode,
    input  logic           master_ack,
    input  logic           scl_fall,
    input  logic           scl_rise,
    input  logic           sda_in,
    output logic           shift_sda,
    output logic           byte_done,
    output i2c_pkg::byte_t rx_byte,
    output logic           slave_ack
);

    import i2c_pkg::*;

    localparam logic [3:0] ACK_SLOT = 4'd8;

    byte_t tx_q;
    logic [3:0] slot;
    logic active;
    logic fall_d;
    logic in_data;

    assign in_data = (slot != ACK_SLOT);

    always_ff @(posedge clk) begin
        if (rst) begin
            active <= 1'b0;
            slot <= '0;
            fall_d <= 1'b0;
            shift_sda <= 1'b1;
            byte_done <= 1'b0;
            slave_ack <= 1'b1;
        end else begin
            // SDA moves one cycle into the SCL low phase
            fall_d <= scl_fall;
            byte_done <= 1'b0;
            if (load) begin
                // Line is already low here, after START or an ACK
                active <= 1'b1;
                slot <= '0;
                shift_sda <= 1'b0;
            end else if (active) begin
                if (fall_d) begin
                    if (in_data) begin
                        shift_sda <= read_mode ? 1'b1 : tx_q[7];
                    end else begin
                        shift_sda <= read_mode ? master_ack : 1'b1;
                    end
                end
                if (scl_rise) begin
                    if (in_data) begin
                        slot <= slot + 1'b1;
                    end else begin
                        slave_ack <= sda_in;
                        byte_done <= 1'b1;
                        active <= 1'b0;
                    end
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            tx_q <= load_byte;
        end else if (active && fall_d && in_data) begin
            tx_q <= {tx_q[6:0], 1'b0};
        end
        if (active && scl_rise && in_data && read_mode) begin
            rx_byte <= {rx_byte[6:0], sda_in};
        end
    end

endmodule

/* verilog/i2c_sequencer.sv */
`timescale 1ns/1ps

module i2c_sequencer #(
    parameter int SCL_HALF_PERIOD = 4
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 start,
    input  i2c_pkg::slave_addr_t slave_addr,
    input  i2c_pkg::op_t         op,
    input  i2c_pkg::byte_t       reg_addr,
    input  i2c_pkg::word_t       wdata,
    output logic                 busy,
    output logic                 done,
    output logic                 nack,
    output i2c_pkg::word_t       rdata,
    output logic                 run,
    input  logic                 scl_rise,
    input  logic                 scl_fall,
    input  logic                 byte_done,
    input  i2c_pkg::byte_t       rx_byte,
    input  logic                 slave_ack,
    input  logic                 shift_sda,
    output logic                 load,
    output i2c_pkg::byte_t       load_byte,
    output logic                 read_mode,
    output logic                 master_ack,
    output logic                 sda_out
);

    import i2c_pkg::*;

    localparam int HC_W = $clog2(SCL_HALF_PERIOD);
    localparam logic [HC_W-1:0] HALF_LAST = HC_W'(SCL_HALF_PERIOD - 1);
    localparam int BC_W = $clog2(DATA_BYTES);
    localparam logic [BC_W-1:0] LAST_BYTE = BC_W'(DATA_BYTES - 1);

    seq_state_t state;
    logic [1:0] phase;
    logic [HC_W-1:0] hcnt;
    logic [BC_W-1:0] byte_cnt;
    logic counting;
    logic accept;

    // Command fields, rw_q is the R/W bit of the next address byte
    slave_addr_t addr_q;
    op_t op_q;
    op_t rw_q;
    byte_t reg_q;
    word_t wdata_q;

    assign accept = (state == ST_IDLE) && start;
    assign busy = (state != ST_IDLE);
    assign counting = (state == ST_START) || (phase == 2'd3);
    assign read_mode = (state == ST_DATA) && (op_q == OP_READ);
    assign master_ack = (byte_cnt == LAST_BYTE);

    // RESTART and STOP: wait SCL low, set SDA, raise SCL, hold a half period
    always_comb begin
        case (state)
            ST_IDLE:             sda_out = 1'b1;
            ST_START:            sda_out = 1'b0;
            ST_RESTART, ST_STOP: sda_out = phase[1] ? (state == ST_RESTART) : shift_sda;
            default:             sda_out = shift_sda;
        endcase
    end

    always_comb begin
        load = 1'b0;
        load_byte = wdata_q[31:24];
        case (state)
            ST_START: begin
                load = (hcnt == HALF_LAST);
                load_byte = {addr_q, rw_q};
            end
            ST_ADDR: begin
                load = byte_done && !slave_ack;
                if (rw_q == OP_WRITE) begin
                    load_byte = reg_q;
                end
            end
            ST_REG: begin
                load = byte_done && !slave_ack && (op_q == OP_WRITE);
            end
            ST_DATA: begin
                load = byte_done && (byte_cnt != LAST_BYTE) && (read_mode || !slave_ack);
            end
            default: begin
                load = 1'b0;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= ST_IDLE;
            phase <= 2'd0;
            hcnt <= '0;
            byte_cnt <= '0;
            run <= 1'b0;
            done <= 1'b0;
            nack <= 1'b0;
            rw_q <= OP_WRITE;
        end else begin
            done <= 1'b0;
            if (counting && hcnt != HALF_LAST) begin
                hcnt <= hcnt + 1'b1;
            end else begin
                hcnt <= '0;
            end
            case (state)
                ST_IDLE: begin
                    if (start) begin
                        state <= ST_START;
                        nack <= 1'b0;
                        rw_q <= OP_WRITE;
                        byte_cnt <= '0;
                    end
                end
                ST_START: begin
                    if (hcnt == HALF_LAST) begin
                        state <= ST_ADDR;
                        run <= 1'b1;
                    end
                end
                ST_ADDR: begin
                    if (byte_done) begin
                        if (slave_ack) begin
                            nack <= 1'b1;
                            state <= ST_STOP;
                        end else if (rw_q == OP_READ) begin
                            state <= ST_DATA;
                        end else begin
                            state <= ST_REG;
                        end
                    end
                end
                ST_REG: begin
                    if (byte_done) begin
                        if (slave_ack) begin
                            nack <= 1'b1;
                            state <= ST_STOP;
                        end else if (op_q == OP_READ) begin
                            state <= ST_RESTART;
                            rw_q <= OP_READ;
                        end else begin
                            state <= ST_DATA;
                        end
                    end
                end
                ST_DATA: begin
                    if (byte_done) begin
                        byte_cnt <= byte_cnt + 1'b1;
                        if (!read_mode && slave_ack) begin
                            nack <= 1'b1;
                            state <= ST_STOP;
                        end else if (byte_cnt == LAST_BYTE) begin
                            state <= ST_STOP;
                        end
                    end
                end
                ST_RESTART, ST_STOP: begin
                    case (phase)
                        2'd0: begin
                            if (scl_fall) begin
                                phase <= 2'd1;
                            end
                        end
                        2'd1: begin
                            phase <= 2'd2;
                        end
                        2'd2: begin
                            if (scl_rise) begin
                                phase <= 2'd3;
                                run <= 1'b0;
                            end
                        end
                        default: begin
                            if (hcnt == HALF_LAST) begin
                                phase <= 2'd0;
                                if (state == ST_STOP) begin
                                    state <= ST_IDLE;
                                    done <= 1'b1;
                                end else begin
                                    state <= ST_START;
                                end
                            end
                        end
                    endcase
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            addr_q <= slave_addr;
            op_q <= op;
            reg_q <= reg_addr;
            wdata_q <= wdata;
        end else if (load && (state == ST_REG || state == ST_DATA)) begin
            wdata_q <= {wdata_q[23:0], 8'h00};
        end
        // Read word assembled MSB first
        if (read_mode && byte_done) begin
            rdata <= {rdata[23:0], rx_byte};
        end
    end

endmodule

/* verilog/i2c_master.sv */
`timescale 1ns/1ps

module i2c_master #(
    parameter int SCL_HALF_PERIOD = 4
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 start,
    input  i2c_pkg::slave_addr_t slave_addr,
    input  i2c_pkg::op_t         op,
    input  i2c_pkg::byte_t       reg_addr,
    input  i2c_pkg::word_t       wdata,
    output logic                 busy,
    output logic                 done,
    output logic                 nack,
    output i2c_pkg::word_t       rdata,
    output logic                 scl,
    output logic                 sda_out,
    input  logic                 sda_in
);

    logic run;
    logic scl_rise;
    logic scl_fall;
    logic load;
    i2c_pkg::byte_t load_byte;
    logic read_mode;
    logic master_ack;
    logic shift_sda;
    logic byte_done;
    i2c_pkg::byte_t rx_byte;
    logic slave_ack;

    i2c_bit_timer #(
        .SCL_HALF_PERIOD(SCL_HALF_PERIOD)
    ) u_bit_timer (
        .clk      (clk),
        .rst      (rst),
        .run      (run),
        .scl      (scl),
        .scl_rise (scl_rise),
        .scl_fall (scl_fall)
    );

    i2c_byte_shifter u_byte_shifter (
        .clk        (clk),
        .rst        (rst),
        .load       (load),
        .load_byte  (load_byte),
        .read_mode  (read_mode),
        .master_ack (master_ack),
        .scl_fall   (scl_fall),
        .scl_rise   (scl_rise),
        .sda_in     (sda_in),
        .shift_sda  (shift_sda),
        .byte_done  (byte_done),
        .rx_byte    (rx_byte),
        .slave_ack  (slave_ack)
    );

    i2c_sequencer #(
        .SCL_HALF_PERIOD(SCL_HALF_PERIOD)
    ) u_sequencer (
        .clk        (clk),
        .rst        (rst),
        .start      (start),
        .slave_addr (slave_addr),
        .op         (op),
        .reg_addr   (reg_addr),
        .wdata      (wdata),
        .busy       (busy),
        .done       (done),
        .nack       (nack),
        .rdata      (rdata),
        .run        (run),
        .scl_rise   (scl_rise),
        .scl_fall   (scl_fall),
        .byte_done  (byte_done),
        .rx_byte    (rx_byte),
        .slave_ack  (slave_ack),
        .shift_sda  (shift_sda),
        .load       (load),
        .load_byte  (load_byte),
        .read_mode  (read_mode),
        .master_ack (master_ack),
        .sda_out    (sda_out)
    );

endmodule

/* tests/i2c_slave_model.sv */
`timescale 1ns/1ps

module i2c_slave_model #(
    parameter logic [6:0] ADDR = 7'h3c
) (
    input  logic clk,
    input  logic rst,
    input  logic scl,
    input  logic sda,
    output logic sda_drv,
    output int   start_count,
    output int   rstart_count,
    output int   stop_count,
    output int   glitch_count
);

    typedef enum logic [2:0] {M_IDLE, M_ADDR, M_REG, M_WDATA, M_RDATA} mode_t;

    logic [31:0] mem [0:255];
    mode_t mode;
    logic scl_q;
    logic sda_q;
    logic in_xfer;
    logic mack;
    logic [3:0] bit_cnt;
    logic [7:0] shreg;
    logic [7:0] reg_ptr;
    logic [31:0] tx_shift;

    always @(posedge clk) begin
        if (rst) begin
            scl_q <= 1'b1;
            sda_q <= 1'b1;
            sda_drv <= 1'b1;
            in_xfer <= 1'b0;
            bit_cnt <= '0;
            mode <= M_IDLE;
            start_count <= 0;
            rstart_count <= 0;
            stop_count <= 0;
            glitch_count <= 0;
            // Fill pattern built from the whole address
            for (int i = 0; i < 256; i++) begin
                mem[i] <= {~i[7:0], i[7:0] ^ 8'h3c, i[7:0] + 8'h11, i[7:0]};
            end
        end else begin
            scl_q <= scl;
            sda_q <= sda;
            // START and STOP follow at most the first SCL rise of a new slot
            if (scl && scl_q && (sda != sda_q)) begin
                if (bit_cnt > 4'd1) begin
                    glitch_count <= glitch_count + 1;
                end else if (!sda) begin
                    if (in_xfer) begin
                        rstart_count <= rstart_count + 1;
                    end else begin
                        start_count <= start_count + 1;
                    end
                    in_xfer <= 1'b1;
                    mode <= M_ADDR;
                    sda_drv <= 1'b1;
                    bit_cnt <= '0;
                end else begin
                    stop_count <= stop_count + 1;
                    in_xfer <= 1'b0;
                    mode <= M_IDLE;
                    sda_drv <= 1'b1;
                    bit_cnt <= '0;
                end
            end else if (scl && !scl_q) begin
                if (bit_cnt < 8) begin
                    shreg <= {shreg[6:0], sda};
                end else begin
                    mack <= sda;
                end
                bit_cnt <= bit_cnt + 1'b1;
            end else if (!scl && scl_q) begin
                if (bit_cnt == 8) begin
                    // Decide the acknowledge slot once the byte is complete
                    case (mode)
                        M_ADDR: begin
                            if (shreg[7:1] == ADDR) begin
                                sda_drv <= 1'b0;
                                if (shreg[0]) begin
                                    mode <= M_RDATA;
                                    tx_shift <= mem[reg_ptr];
                                end else begin
                                    mode <= M_REG;
                                end
                            end else begin
                                mode <= M_IDLE;
                            end
                        end
                        M_REG: begin
                            reg_ptr <= shreg;
                            sda_drv <= 1'b0;
                            mode <= M_WDATA;
                        end
                        M_WDATA: begin
                            mem[reg_ptr] <= {mem[reg_ptr][23:0], shreg};
                            sda_drv <= 1'b0;
                        end
                        default: begin
                            sda_drv <= 1'b1;
                        end
                    endcase
                end else if (bit_cnt == 9) begin
                    bit_cnt <= '0;
                    // Own address ACK also reads back as 0 here
                    if (mode == M_RDATA && !mack) begin
                        sda_drv <= tx_shift[31];
                        tx_shift <= {tx_shift[30:0], 1'b0};
                    end else begin
                        sda_drv <= 1'b1;
                        if (mode == M_RDATA) begin
                            mode <= M_IDLE;
                        end
                    end
                end else if (mode == M_RDATA && bit_cnt != 0) begin
                    sda_drv <= tx_shift[31];
                    tx_shift <= {tx_shift[30:0], 1'b0};
                end
            end
        end
    end

endmodule

/* tests/tb_i2c_master.sv */
`timescale 1ns/1ps

module tb_i2c_master;

    import i2c_pkg::*;

    localparam logic [6:0] SLV_ADDR = 7'h3c;
    localparam int TIMEOUT = 5000;

    logic clk = 1'b0;
    logic rst;
    logic start;
    logic [6:0] slave_addr;
    op_t op;
    logic [7:0] reg_addr;
    logic [31:0] wdata;
    logic busy;
    logic done;
    logic nack;
    logic [31:0] rdata;
    logic scl;
    logic sda_out;
    logic sda_drv;
    logic sda;
    int start_count;
    int rstart_count;
    int stop_count;
    int glitch_count;

    logic [31:0] ref_mem [0:255];
    logic [7:0] written [$];
    int errors = 0;
    int checks = 0;
    int s_start;
    int s_rstart;
    int s_stop;
    int s_glitch;
    logic last_nack;
    logic [31:0] last_rdata;

    assign sda = sda_out & sda_drv;

    always #4 clk = ~clk;

    i2c_master #(
        .SCL_HALF_PERIOD(4)
    ) u_i2c_master (
        .clk(clk), .rst(rst), .start(start), .slave_addr(slave_addr), .op(op),
        .reg_addr(reg_addr), .wdata(wdata), .busy(busy), .done(done), .nack(nack),
        .rdata(rdata), .scl(scl), .sda_out(sda_out), .sda_in(sda)
    );

    i2c_slave_model #(
        .ADDR(SLV_ADDR)
    ) u_slave (
        .clk(clk), .rst(rst), .scl(scl), .sda(sda), .sda_drv(sda_drv),
        .start_count(start_count), .rstart_count(rstart_count),
        .stop_count(stop_count), .glitch_count(glitch_count)
    );

    task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
        checks++;
        if (exp !== act) begin
            $display("Fail time=%0t %s expected=%h actual=%h", $time, name, exp, act);
            errors++;
        end
    endtask

    task automatic send_command(input logic [6:0] a, input op_t o, input logic [7:0] r,
                                input logic [31:0] d);
        @(posedge clk);
        start <= 1'b1;
        slave_addr <= a;
        op <= o;
        reg_addr <= r;
        wdata <= d;
        @(posedge clk);
        start <= 1'b0;
    endtask

    task automatic wait_for_done();
        int n;
        logic seen;
        n = 0;
        seen = 1'b0;
        while (!seen && n < TIMEOUT) begin
            @(negedge clk);
            seen = done;
            n++;
        end
        if (!seen) begin
            $display("Timeout at %0t, transfer never signalled done", $time);
            errors++;
        end else begin
            check_value("busy", 32'd0, busy);
            last_nack = nack;
            last_rdata = rdata;
        end
    endtask

    task automatic take_snapshot();
        s_start = start_count;
        s_rstart = rstart_count;
        s_stop = stop_count;
        s_glitch = glitch_count;
    endtask

    // STOP is seen by the monitor a cycle or two after done
    task automatic check_framing(input int n_start, input int n_rstart, input int n_stop);
        repeat (4) @(negedge clk);
        check_value("start_count", n_start, start_count - s_start);
        check_value("rstart_count", n_rstart, rstart_count - s_rstart);
        check_value("stop_count", n_stop, stop_count - s_stop);
        check_value("glitch_count", 0, glitch_count - s_glitch);
    endtask

    task automatic run_write(input logic [7:0] r, input logic [31:0] d);
        take_snapshot();
        send_command(SLV_ADDR, OP_WRITE, r, d);
        wait_for_done();
        check_value("nack", 32'd0, last_nack);
        ref_mem[r] = d;
        check_value("slave mem", ref_mem[r], u_slave.mem[r]);
        check_framing(1, 0, 1);
    endtask

    task automatic run_read(input logic [7:0] r);
        take_snapshot();
        send_command(SLV_ADDR, OP_READ, r, $urandom);
        wait_for_done();
        check_value("nack", 32'd0, last_nack);
        check_value("rdata", ref_mem[r], last_rdata);
        check_framing(1, 1, 1);
    endtask

    initial begin
        logic [7:0] r;
        logic [7:0] r2;
        logic [6:0] bad_addr;
        logic [31:0] d;
        logic [31:0] d2;
        void'($urandom(32'h2d97));
        rst = 1'b1;
        start = 1'b0;
        slave_addr = '0;
        op = OP_WRITE;
        reg_addr = '0;
        wdata = '0;
        repeat (3) @(posedge clk);
        rst <= 1'b0;
        for (int i = 0; i < 256; i++) begin
            ref_mem[i] = u_slave.mem[i];
        end

        // Idle bus after reset
        repeat (10) begin
            @(negedge clk);
            check_value("scl", 32'd1, scl);
            check_value("sda_out", 32'd1, sda_out);
            check_value("busy", 32'd0, busy);
            check_value("done", 32'd0, done);
        end

        for (int i = 0; i < 20; i++) begin
            r = 8'($urandom);
            run_write(r, $urandom);
            written.push_back(r);
        end

        for (int i = 0; i < 20; i++) begin
            if (i % 2 == 0) begin
                r = written[$urandom % written.size()];
            end else begin
                r = 8'($urandom);
            end
            run_read(r);
        end

        // Wrong slave address
        bad_addr = 7'($urandom);
        if (bad_addr == SLV_ADDR) begin
            bad_addr = ~bad_addr;
        end
        take_snapshot();
        send_command(bad_addr, op_t'($urandom % 2), 8'($urandom), $urandom);
        wait_for_done();
        check_value("nack", 32'd1, last_nack);
        check_framing(1, 0, 1);
        for (int i = 0; i < 256; i++) begin
            if (u_slave.mem[i] !== ref_mem[i]) begin
                $display("Slave memory changed at register %0d after an address nack", i);
                errors++;
            end
        end

        // Second start while busy must be dropped
        r = 8'($urandom);
        r2 = r + 8'd1 + 8'($urandom % 200);
        d = $urandom;
        d2 = $urandom;
        take_snapshot();
        send_command(SLV_ADDR, OP_WRITE, r, d);
        repeat (20) @(negedge clk);
        check_value("busy", 32'd1, busy);
        send_command(SLV_ADDR, OP_WRITE, r2, d2);
        wait_for_done();
        check_value("nack", 32'd0, last_nack);
        ref_mem[r] = d;
        check_framing(1, 0, 1);
        check_value("slave mem", ref_mem[r], u_slave.mem[r]);
        check_value("slave mem", ref_mem[r2], u_slave.mem[r2]);
        repeat (50) @(negedge clk);
        check_value("busy", 32'd0, busy);
        check_value("start_count", s_start + 1, start_count);

        $display("Errors: %0d of %0d checks", errors, checks);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

/* i2c_master.f */
verilog/i2c_pkg.sv
verilog/i2c_bit_timer.sv
verilog/i2c_byte_shifter.sv
verilog/i2c_sequencer.sv
verilog/i2c_master.sv
tests/i2c_slave_model.sv
tests/tb_i2c_master.sv

/* Makefile */
.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing -f i2c_master.f --top-module tb_i2c_master -o Vtb_i2c_master

run: build
	./obj_dir/Vtb_i2c_master | tee sim.log
	grep -q "Result: PASSED" sim.log

lint:
	verilator --lint-only -Wall verilog/i2c_pkg.sv verilog/i2c_bit_timer.sv \
		verilog/i2c_byte_shifter.sv verilog/i2c_sequencer.sv verilog/i2c_master.sv \
		--top-module i2c_master

clean:
	rm -rf obj_dir sim.log
